// File: rtl/ldst_defs.svh
`ifndef LDST_DEFS_SVH
`define LDST_DEFS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////
`define WIDTH_DATA		32		// Data word
`define WIDTH_ADDR		6		// Data memory address
`define WIDTH_STRIDE	4		// Unsigned stride
`define WIDTH_ISSUE		4		// Issue number
`define WIDTH_DST		3		// Destination register number

//////////////////////////////////////////////////
// Depths
//////////////////////////////////////////////////
`define DEPTH_BUFF		4		// Load data buffer entries
`define SIZE_DMEM		(1 << `WIDTH_ADDR)	// Words in data memory

`endif

// File: rtl/ldst_pkg.sv
`include "ldst_defs.svh"

package ldst_pkg;

	//////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////
	typedef logic [`WIDTH_DATA-1:0]		data_t;
	typedef logic [`WIDTH_ADDR-1:0]		address_t;		// Also used for lengths
	typedef logic [`WIDTH_STRIDE-1:0]	stride_t;
	typedef logic [`WIDTH_ISSUE-1:0]	issue_no_t;
	typedef logic [`WIDTH_DST-1:0]		dst_t;

	//////////////////////////////////////////////////
	// Command from the front end
	//////////////////////////////////////////////////
	typedef struct packed {
		logic			v;
		logic [1:0]		op_type;		// 3 is a memory command
		logic			op_class;		// Load 0, store 1
		dst_t			dst;
		issue_no_t		issue_no;
	} command_t;

	// One memory stream request
	typedef struct packed {
		logic			req;			// Single-cycle pulse
		address_t		len;			// Zero means full memory
		stride_t		stride;
		address_t		base;
	} access_t;

	typedef struct packed {
		access_t		ld;
		access_t		st;
	} ldst_req_t;

	// Write-back token of a finished command
	typedef struct packed {
		logic			v;
		logic			op_class;
		dst_t			dst;
		issue_no_t		issue_no;
	} wb_token_t;

	typedef enum logic [1:0] {
		CH_IDLE,
		CH_ISSUE,
		CH_ACCESS,
		CH_DRAIN
	} chan_state_t;

endpackage

// File: rtl/ldst_channel.sv
`timescale 1ns/10ps
`include "ldst_defs.svh"

module ldst_channel
	import ldst_pkg::*;
#(
	parameter bit LOAD_DIR = 1'b1				// 1 load channel, 0 store channel
)(
	input	logic		clock,
	input	logic		arst_n,
	input	logic		stall,					// Write-back stall
	input	logic		start,					// Decoded command for this direction
	input	address_t	len,
	input	stride_t	stride,
	input	address_t	base,
	input	wb_token_t	token_in,
	input	data_t		data_in,				// Fill word for stores
	input	logic		grant,					// Word returned by memory
	input	logic		acc_end,				// Memory stream finished
	input	data_t		mem_data,
	output	access_t	access,
	output	data_t		data_out,
	output	logic		data_valid,
	output	logic		ready,					// Buffer has room
	output	logic		busy,
	output	logic		fin,					// Completion pulse
	output	wb_token_t	token_out
);

	localparam int WIDTH_PTR = $clog2(`DEPTH_BUFF);

	chan_state_t			state;
	chan_state_t			state_nxt;

	address_t				len_q;
	stride_t				stride_q;
	address_t				base_q;
	wb_token_t				token_q;
	data_t					fill_q;

	data_t					buff [`DEPTH_BUFF];
	logic [WIDTH_PTR-1:0]	wr_ptr;
	logic [WIDTH_PTR-1:0]	rd_ptr;
	logic [WIDTH_PTR:0]		count;
	logic					push;
	logic					pop;
	logic					empty;

	//////////////////////////////////////////////////
	// Channel FSM
	//////////////////////////////////////////////////
	always_comb begin
		state_nxt = state;
		case (state)
			CH_IDLE:	if (start) state_nxt = CH_ISSUE;
			CH_ISSUE:	state_nxt = CH_ACCESS;
			CH_ACCESS:	if (acc_end) state_nxt = LOAD_DIR ? CH_DRAIN : CH_IDLE;
			CH_DRAIN:	if (empty) state_nxt = CH_IDLE;
			default:	state_nxt = CH_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= CH_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Request and token captured when the command is taken
	always_ff @(posedge clock) begin
		if ((state == CH_IDLE) && start) begin
			len_q    <= len;
			stride_q <= stride;
			base_q   <= base;
			token_q  <= token_in;
			fill_q   <= data_in;
		end
	end

	assign access.req    = (state == CH_ISSUE);	// One cycle after the command
	assign access.len    = len_q;
	assign access.stride = stride_q;
	assign access.base   = base_q;

	assign busy      = (state != CH_IDLE);
	assign token_out = token_q;
	assign fin       = LOAD_DIR ? ((state == CH_DRAIN) && empty) :
							((state == CH_ACCESS) && acc_end);

	//////////////////////////////////////////////////
	// Load data buffer
	//////////////////////////////////////////////////
	assign empty = (count == '0);
	assign push  = LOAD_DIR && grant;
	assign pop   = !empty && !stall;

	always_ff @(posedge clock) begin
		if (push) begin
			buff[wr_ptr] <= mem_data;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;
			endcase
		end
	end

	// One word may still be in flight from the memory
	assign ready      = LOAD_DIR ? (count < (`DEPTH_BUFF - 1)) : 1'b1;
	assign data_valid = LOAD_DIR && !empty;
	assign data_out   = LOAD_DIR ? buff[rd_ptr] : fill_q;

endmodule

// File: rtl/ld_st_unit.sv
`timescale 1ns/10ps
`include "ldst_defs.svh"

module ld_st_unit
	import ldst_pkg::*;
(
	input	logic		clock,
	input	logic		arst_n,
	input	logic		stall,
	input	issue_no_t	issue_no,				// Current issue number
	input	logic		req,
	input	command_t	command,
	input	data_t		src_data1,				// Length and stride
	input	data_t		src_data2,				// Base address
	input	data_t		src_data3,				// Fill word
	input	logic		ld_grant,
	input	logic		st_grant,
	input	logic		ld_end,
	input	logic		st_end,
	input	data_t		ld_data,
	output	ldst_req_t	ldst_req,
	output	data_t		st_data,
	output	logic		ld_ready,
	output	wb_token_t	wb_token,
	output	data_t		wb_data,
	output	logic		wb_valid,
	output	logic		done,
	output	logic		ld_busy,
	output	logic		st_busy,
	output	logic		cmd_drop
);

	logic			mem_cmd;
	logic			ld_cmd;
	logic			st_cmd;
	address_t		len;
	stride_t		stride;
	address_t		base;
	wb_token_t		cmd_token;

	logic			ld_fin;
	logic			st_fin;
	wb_token_t		ld_tok;
	wb_token_t		st_tok;
	issue_no_t		dist_ld;
	issue_no_t		dist_st;
	logic			sel_ld;

	logic			pend_v;
	wb_token_t		pend_tok;
	logic			drop_q;

	//////////////////////////////////////////////////
	// Command decode
	//////////////////////////////////////////////////
	assign mem_cmd = req && command.v && (command.op_type == 2'd3);
	assign ld_cmd  = mem_cmd && !command.op_class;
	assign st_cmd  = mem_cmd && command.op_class;

	assign len    = src_data1[`WIDTH_ADDR-1:0];
	assign stride = src_data1[`WIDTH_DATA-1 -: `WIDTH_STRIDE];
	assign base   = src_data2[`WIDTH_ADDR-1:0];

	assign cmd_token = '{v: 1'b1, op_class: command.op_class,
						dst: command.dst, issue_no: command.issue_no};

	ldst_channel #(.LOAD_DIR(1'b1)) ld_chan (
		.clock		(clock),
		.arst_n		(arst_n),
		.stall		(stall),
		.start		(ld_cmd),
		.len		(len),
		.stride		(stride),
		.base		(base),
		.token_in	(cmd_token),
		.data_in	(src_data3),
		.grant		(ld_grant),
		.acc_end	(ld_end),
		.mem_data	(ld_data),
		.access		(ldst_req.ld),
		.data_out	(wb_data),
		.data_valid	(wb_valid),
		.ready		(ld_ready),
		.busy		(ld_busy),
		.fin		(ld_fin),
		.token_out	(ld_tok)
	);

	ldst_channel #(.LOAD_DIR(1'b0)) st_chan (
		.clock		(clock),
		.arst_n		(arst_n),
		.stall		(stall),
		.start		(st_cmd),
		.len		(len),
		.stride		(stride),
		.base		(base),
		.token_in	(cmd_token),
		.data_in	(src_data3),
		.grant		(st_grant),
		.acc_end	(st_end),
		.mem_data	('0),
		.access		(ldst_req.st),
		.data_out	(st_data),
		.data_valid	(),
		.ready		(),
		.busy		(st_busy),
		.fin		(st_fin),
		.token_out	(st_tok)
	);

	//////////////////////////////////////////////////
	// Write-back token selection
	//////////////////////////////////////////////////
	assign dist_ld = issue_no - ld_tok.issue_no;	// Unsigned issue distance
	assign dist_st = issue_no - st_tok.issue_no;
	assign sel_ld  = ld_fin && (!st_fin || (dist_ld > dist_st));

	// Loser of a simultaneous finish goes out next cycle
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pend_v <= 1'b0;
			drop_q <= 1'b0;
		end else begin
			pend_v <= ld_fin && st_fin;
			drop_q <= (ld_cmd && ld_busy) || (st_cmd && st_busy);
		end
	end

	always_ff @(posedge clock) begin
		if (ld_fin && st_fin) begin
			pend_tok <= sel_ld ? st_tok : ld_tok;
		end
	end

	assign done = pend_v || ld_fin || st_fin;

	always_comb begin
		wb_token = pend_v ? pend_tok : (sel_ld ? ld_tok : st_tok);
		wb_token.v = done;
	end

	assign cmd_drop = drop_q;

endmodule

// File: rtl/strided_dmem.sv
`timescale 1ns/10ps
`include "ldst_defs.svh"

module strided_dmem
	import ldst_pkg::*;
(
	input	logic		clock,
	input	logic		arst_n,
	input	ldst_req_t	ldst_req,
	input	data_t		st_data,
	input	logic		ld_ready,				// Load channel has room
	output	data_t		ld_data,
	output	logic		ld_grant,
	output	logic		st_grant,
	output	logic		ld_end,
	output	logic		st_end
);

	data_t		mem [`SIZE_DMEM];

	logic		ld_act;
	address_t	ld_addr;
	address_t	ld_cnt;
	address_t	ld_lim;					// Index of last word
	stride_t	ld_stride;
	logic		ld_issue;
	logic		ld_last;
	logic		ld_grant_q;
	logic		ld_last_q;
	logic		ld_end_q;

	logic		st_act;
	address_t	st_addr;
	address_t	st_cnt;
	address_t	st_lim;
	stride_t	st_stride;
	logic		st_last;
	logic		st_grant_q;
	logic		st_last_q;
	logic		st_end_q;

	assign ld_issue = ld_act && ld_ready;
	assign ld_last  = ld_issue && (ld_cnt == ld_lim);
	assign st_last  = st_act && (st_cnt == st_lim);

	//////////////////////////////////////////////////
	// Memory array
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (st_act) begin
			mem[st_addr] <= st_data;
		end
		if (ld_issue) begin
			ld_data <= mem[ld_addr];	// Old word on a same-address collision
		end
	end

	//////////////////////////////////////////////////
	// Strided address counters
	//////////////////////////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			ld_act     <= 1'b0;
			ld_grant_q <= 1'b0;
			ld_last_q  <= 1'b0;
			ld_end_q   <= 1'b0;
		end else begin
			if (ldst_req.ld.req) begin
				ld_act <= 1'b1;
			end else if (ld_last) begin
				ld_act <= 1'b0;
			end
			ld_grant_q <= ld_issue;
			ld_last_q  <= ld_last;
			ld_end_q   <= ld_last_q;	// One cycle after the last grant
		end
	end

	always_ff @(posedge clock) begin
		if (ldst_req.ld.req) begin
			ld_addr   <= ldst_req.ld.base;
			ld_cnt    <= '0;
			ld_lim    <= ldst_req.ld.len - 1'b1;	// Zero length wraps to 63
			ld_stride <= ldst_req.ld.stride;
		end else if (ld_issue) begin
			ld_addr <= ld_addr + address_t'(ld_stride);
			ld_cnt  <= ld_cnt + 1'b1;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			st_act     <= 1'b0;
			st_grant_q <= 1'b0;
			st_last_q  <= 1'b0;
			st_end_q   <= 1'b0;
		end else begin
			if (ldst_req.st.req) begin
				st_act <= 1'b1;
			end else if (st_last) begin
				st_act <= 1'b0;
			end
			st_grant_q <= st_act;
			st_last_q  <= st_last;
			st_end_q   <= st_last_q;
		end
	end

	always_ff @(posedge clock) begin
		if (ldst_req.st.req) begin
			st_addr   <= ldst_req.st.base;
			st_cnt    <= '0;
			st_lim    <= ldst_req.st.len - 1'b1;
			st_stride <= ldst_req.st.stride;
		end else if (st_act) begin
			st_addr <= st_addr + address_t'(st_stride);
			st_cnt  <= st_cnt + 1'b1;
		end
	end

	assign ld_grant = ld_grant_q;
	assign ld_end   = ld_end_q;
	assign st_grant = st_grant_q;
	assign st_end   = st_end_q;

endmodule

// File: rtl/ldst_top.sv
`timescale 1ns/10ps

module ldst_top
	import ldst_pkg::*;
(
	input	logic		clock,
	input	logic		arst_n,
	input	logic		req,
	input	command_t	command,
	input	data_t		src_data1,
	input	data_t		src_data2,
	input	data_t		src_data3,
	input	logic		stall,
	input	issue_no_t	issue_no,
	output	wb_token_t	wb_token,
	output	data_t		wb_data,
	output	logic		wb_valid,
	output	logic		done,
	output	logic		ld_busy,
	output	logic		st_busy,
	output	logic		cmd_drop
);

	ldst_req_t	ldst_req;
	data_t		st_data;
	data_t		ld_data;
	logic		ld_ready;
	logic		ld_grant;
	logic		st_grant;
	logic		ld_end;
	logic		st_end;

	//////////////////////////////////////////////////
	// Load/store unit and its memory
	//////////////////////////////////////////////////
	ld_st_unit ldst_unit_i (
		.clock		(clock),
		.arst_n		(arst_n),
		.stall		(stall),
		.issue_no	(issue_no),
		.req		(req),
		.command	(command),
		.src_data1	(src_data1),
		.src_data2	(src_data2),
		.src_data3	(src_data3),
		.ld_grant	(ld_grant),
		.st_grant	(st_grant),
		.ld_end		(ld_end),
		.st_end		(st_end),
		.ld_data	(ld_data),
		.ldst_req	(ldst_req),
		.st_data	(st_data),
		.ld_ready	(ld_ready),
		.wb_token	(wb_token),
		.wb_data	(wb_data),
		.wb_valid	(wb_valid),
		.done		(done),
		.ld_busy	(ld_busy),
		.st_busy	(st_busy),
		.cmd_drop	(cmd_drop)
	);

	strided_dmem dmem_i (
		.clock		(clock),
		.arst_n		(arst_n),
		.ldst_req	(ldst_req),
		.st_data	(st_data),
		.ld_ready	(ld_ready),			// Back-pressure from load buffer
		.ld_data	(ld_data),
		.ld_grant	(ld_grant),
		.st_grant	(st_grant),
		.ld_end		(ld_end),
		.st_end		(st_end)
	);

endmodule

// File: dv/ldst_sva.sv
`timescale 1ns/10ps

module ldst_sva
	import ldst_pkg::*;
(
	input	logic		clock,
	input	logic		arst_n,
	input	logic		done,
	input	wb_token_t	wb_token,
	input	logic		wb_valid,
	input	logic		ld_busy,
	input	ldst_req_t	ldst_req
);

	int			fail_cnt = 0;				// Failed assertions so far

	//////////////////////////////////////////////////
	// Write-back and request rules
	//////////////////////////////////////////////////
	done_distinct: assert property (@(posedge clock) disable iff (!arst_n)
		done && $past(done) |-> (wb_token.issue_no != $past(wb_token.issue_no)))
		else begin
			fail_cnt++;
			$error("done pulsed on two cycles for the same issue number");
		end

	// An idle load channel has drained its buffer
	valid_when_idle: assert property (@(posedge clock) disable iff (!arst_n)
		!ld_busy |-> !wb_valid)
		else begin
			fail_cnt++;
			$error("wb_valid high while the load channel is idle");
		end

	// A load request only leaves an idle channel
	req_from_idle: assert property (@(posedge clock) disable iff (!arst_n)
		$rose(ldst_req.ld.req) |-> !$past(ld_busy))
		else begin
			fail_cnt++;
			$error("load request raised while the load channel was busy");
		end

endmodule

bind ld_st_unit ldst_sva sva_i (
	.clock		(clock),
	.arst_n		(arst_n),
	.done		(done),
	.wb_token	(wb_token),
	.wb_valid	(wb_valid),
	.ld_busy	(ld_busy),
	.ldst_req	(ldst_req)
);

// File: dv/ldst_tb.sv
`timescale 1ns/10ps
`include "ldst_defs.svh"

module ldst_tb
	import ldst_pkg::*;
();

	localparam int N_FILL = 64;
	localparam int N_RAND = 8;
	localparam int N_LONG = 4;
	localparam int N_CMDS = N_FILL + 3 * N_RAND + N_LONG + 2 + 3 + 4;
	localparam int LIMIT  = 200 * N_CMDS;			// Cycle budget for the whole run

	logic		clock = 1'b0;
	logic		arst_n;
	logic		req;
	command_t	command;
	data_t		src_data1;
	data_t		src_data2;
	data_t		src_data3;
	logic		stall;
	issue_no_t	issue_no;
	wb_token_t	wb_token;
	data_t		wb_data;
	logic		wb_valid;
	logic		done;
	logic		ld_busy;
	logic		st_busy;
	logic		cmd_drop;

	data_t		mem_model [`SIZE_DMEM];
	data_t		exp_words [$];					// Load words in return order
	wb_token_t	exp_toks [$];					// Tokens in done order
	issue_no_t	issue_cnt;
	int			errors;
	int			cycles;
	int			drops;
	int			stall_left;
	logic		stall_en;
	string		test_name;

	ldst_top dut_i (.*);

	always #5 clock = ~clock;

	assign issue_no = issue_cnt;					// Next issue number

	//////////////////////////////////////////////////
	// Command drivers and model
	//////////////////////////////////////////////////
	task automatic drive_cmd(input logic [1:0] op_type, input logic op_class, input dst_t dst,
			input data_t s1, input data_t s2, input data_t s3);
		@(negedge clock);
		req       = 1'b1;
		command   = '{v: 1'b1, op_type: op_type, op_class: op_class, dst: dst,
						issue_no: issue_cnt};
		src_data1 = s1;
		src_data2 = s2;
		src_data3 = s3;
		issue_cnt = issue_cnt + 1'b1;
	endtask

	task automatic end_cmds();
		@(negedge clock);
		req = 1'b0;
	endtask

	// Memory command and its model update at send time
	task automatic issue_mem(input logic op_class, input address_t len, input stride_t stride,
			input address_t base, input data_t fill);
		address_t	addr;
		int			n;
		dst_t		dst;
		data_t		s1;
		data_t		s2;
		dst  = dst_t'($urandom);
		n    = (len == '0) ? `SIZE_DMEM : int'(len);
		addr = base;
		exp_toks.push_back('{v: 1'b1, op_class: op_class, dst: dst, issue_no: issue_cnt});
		for (int i = 0; i < n; i++) begin
			if (op_class) mem_model[addr] = fill;
			else exp_words.push_back(mem_model[addr]);
			addr = addr + address_t'(stride);		// Wraps modulo memory size
		end
		s1 = $urandom;
		s1[`WIDTH_DATA-1 -: `WIDTH_STRIDE] = stride;
		s1[`WIDTH_ADDR-1:0] = len;
		s2 = $urandom;
		s2[`WIDTH_ADDR-1:0] = base;
		drive_cmd(2'd3, op_class, dst, s1, s2, fill);
	endtask

	task automatic wait_idle();
		do @(negedge clock);
		while (ld_busy || st_busy || exp_toks.size() != 0 || exp_words.size() != 0);
	endtask

	//////////////////////////////////////////////////
	// Monitors
	//////////////////////////////////////////////////
	always @(posedge clock) begin
		if (arst_n) begin
			if (wb_valid && !stall) begin
				assert (exp_words.size() != 0) else begin
					errors++;
					$display("%s: load word arrived with none expected", test_name);
				end
				if (exp_words.size() != 0) begin
					assert (wb_data == exp_words[0]) else begin
						errors++;
						$display("FAILED %s: expected %h, actual %h", test_name,
							exp_words[0], wb_data);
					end
					void'(exp_words.pop_front());
				end
			end
			if (done) begin
				assert (exp_toks.size() != 0) else begin
					errors++;
					$display("%s: done pulse with no command outstanding", test_name);
				end
				if (exp_toks.size() != 0) begin
					assert (wb_token == exp_toks[0]) else begin
						errors++;
						$display("FAILED %s: expected %h, actual %h", test_name,
							exp_toks[0], wb_token);
					end
					void'(exp_toks.pop_front());
				end
			end
			if (cmd_drop) drops++;
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Timeout after %0d cycles", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// Random write-back stall periods
	always @(negedge clock) begin
		if (stall_en && stall_left != 0) begin
			stall      = 1'b1;
			stall_left = stall_left - 1;
		end else if (stall_en && ($urandom % 4) == 0) begin
			stall      = 1'b1;
			stall_left = $urandom % 6;
		end else begin
			stall      = 1'b0;
			stall_left = 0;
		end
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial begin
		logic [1:0]	op_other;
		int			drops_before;
		void'($urandom(3));
		arst_n = 1'b0;
		req = 1'b0;
		command = '0;
		src_data1 = '0;
		src_data2 = '0;
		src_data3 = '0;
		stall = 1'b0;
		stall_en = 1'b0;
		stall_left = 0;
		issue_cnt = '0;
		errors = 0;
		cycles = 0;
		drops = 0;
		test_name = "reset";
		repeat (10) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;

		test_name = "fill_readback";
		for (int i = 0; i < N_FILL; i++) begin
			issue_mem(1'b1, 6'd1, 4'd1, address_t'(i), $urandom);
			end_cmds();
			wait_idle();
		end
		for (int i = 0; i < N_RAND; i++) begin
			issue_mem(1'b0, address_t'($urandom), stride_t'($urandom), address_t'($urandom), '0);
			end_cmds();
			wait_idle();
		end

		test_name = "strided";
		for (int i = 0; i < N_RAND; i++) begin
			issue_mem(1'b1, address_t'($urandom), stride_t'($urandom), address_t'($urandom),
				$urandom);
			end_cmds();
			wait_idle();
		end
		for (int i = 0; i < N_RAND; i++) begin
			issue_mem(1'b0, address_t'($urandom), stride_t'($urandom), address_t'($urandom), '0);
			end_cmds();
			wait_idle();
		end

		test_name = "back_pressure";
		stall_en = 1'b1;
		for (int i = 0; i < N_LONG; i++) begin
			issue_mem(1'b0, 6'd0, stride_t'($urandom), address_t'($urandom), '0);
			end_cmds();
			wait_idle();
		end
		stall_en = 1'b0;
		@(negedge clock);

		// Equal-length load and store finish together and the older token goes first
		test_name = "token_order";
		issue_mem(1'b0, 6'd8, 4'd1, 6'd32, '0);
		issue_mem(1'b1, 6'd8, 4'd1, 6'd0, $urandom);
		end_cmds();
		wait_idle();

		test_name = "drop";
		drops_before = drops;
		issue_mem(1'b1, 6'd0, 4'd1, 6'd0, $urandom);
		drive_cmd(2'd3, 1'b1, 3'd5, {4'd1, 28'd0}, '0, $urandom);	// Store channel busy
		end_cmds();
		wait_idle();
		assert (drops == drops_before + 1) else begin
			errors++;
			$display("FAILED %s: expected %0d, actual %0d", test_name, drops_before + 1, drops);
		end
		issue_mem(1'b0, 6'd0, 4'd1, 6'd0, '0);
		end_cmds();
		wait_idle();

		test_name = "non_memory";
		for (int i = 0; i < 4; i++) begin
			op_other = 2'($urandom % 3);
			drive_cmd(op_other, 1'($urandom), dst_t'($urandom), $urandom, $urandom, $urandom);
		end
		end_cmds();
		repeat (20) begin
			@(negedge clock);
			assert (!done && !wb_valid && !ld_busy && !st_busy) else begin
				errors++;
				$display("%s: non-memory command started the unit", test_name);
			end
		end

		errors = errors + dut_i.ldst_unit_i.sva_i.fail_cnt;	// Bound assertion failures
		$display("Errors: %0d, words left: %0d, tokens left: %0d, drops: %0d, cycles: %0d",
			errors, exp_words.size(), exp_toks.size(), drops, cycles);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+rtl
rtl/ldst_pkg.sv
rtl/ldst_channel.sv
rtl/ld_st_unit.sv
rtl/strided_dmem.sv
rtl/ldst_top.sv
dv/ldst_sva.sv
dv/ldst_tb.sv

// File: Makefile
all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module ldst_tb -o ldst_sim

run: build
	./obj_dir/ldst_sim | tee sim.log
	grep -q "PASS: all tests" sim.log

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module ldst_tb

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
